//--- Bender.yml
package:
  name: pio

sources:
  - files:
      - logic/pio_isa_pkg.sv
      - logic/pio_host_pkg.sv
      - logic/pio_fifo.sv
      - logic/pio_machine.sv
      - logic/pio_pin_merge.sv
      - logic/pio_host_port.sv
      - logic/pio_top.sv
  - target: simulation
    files:
      - test/pio_clock_gen.sv
      - test/pio_tb.sv

//--- logic/pio_fifo.sv
`timescale 1ns/1ns

module pio_fifo (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic        pull,
  input  logic [31:0] din,
  output logic [31:0] dout,
  output logic        empty,
  output logic        full
);

  logic [31:0] mem [pio_isa_pkg::fifo_depth];
  logic [$clog2(pio_isa_pkg::fifo_depth)-1:0] rd_ptr;
  logic [$clog2(pio_isa_pkg::fifo_depth)-1:0] wr_ptr;
  logic [$clog2(pio_isa_pkg::fifo_depth+1)-1:0] count;
  logic do_push;
  logic do_pull;

  assign do_push = push && !full;
  assign do_pull = pull && !empty;
  assign empty   = (count == 0);
  assign full    = (count == pio_isa_pkg::fifo_depth);
  assign dout    = mem[rd_ptr];  // Oldest entry

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pull) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither, no change
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("FIFO push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) pull |-> !empty)
    else $error("FIFO pull while empty");

endmodule

//--- logic/pio_host_pkg.sv
package pio_host_pkg;

  localparam int base_w  = 5;
  localparam int count_w = 3;

  // Field positions in din for act_set_pins
  localparam int set_count_lsb = 0;
  localparam int set_base_lsb  = 3;
  localparam int out_count_lsb = 8;
  localparam int out_base_lsb  = 11;
  localparam int in_base_lsb   = 19;

  typedef enum logic [3:0] {
    act_load_instr  = 4'd1,
    act_set_wrap    = 4'd2,
    act_read_rx     = 4'd3,
    act_write_tx    = 4'd4,
    act_set_pins    = 4'd5,
    act_enable      = 4'd6,
    act_set_jmp_pin = 4'd11
  } host_action_e;

endpackage

//--- logic/pio_host_port.sv
`timescale 1ns/1ns

module pio_host_port (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  output logic                              ack,
  input  logic [3:0]                        action,
  input  logic                              mindex,
  input  logic [4:0]                        index,
  input  logic [31:0]                       din,
  output logic [31:0]                       dout,
  output logic [1:0]                        en,
  output logic [pio_isa_pkg::pc_w-1:0]      pstart0,
  output logic [pio_isa_pkg::pc_w-1:0]      pend0,
  output logic [pio_host_pkg::base_w-1:0]   out_base0,
  output logic [pio_host_pkg::count_w-1:0]  out_count0,
  output logic [pio_host_pkg::base_w-1:0]   set_base0,
  output logic [pio_host_pkg::count_w-1:0]  set_count0,
  output logic [pio_host_pkg::base_w-1:0]   in_base0,
  output logic [pio_host_pkg::base_w-1:0]   jmp_pin0,
  output logic [pio_isa_pkg::pc_w-1:0]      pstart1,
  output logic [pio_isa_pkg::pc_w-1:0]      pend1,
  output logic [pio_host_pkg::base_w-1:0]   out_base1,
  output logic [pio_host_pkg::count_w-1:0]  out_count1,
  output logic [pio_host_pkg::base_w-1:0]   set_base1,
  output logic [pio_host_pkg::count_w-1:0]  set_count1,
  output logic [pio_host_pkg::base_w-1:0]   in_base1,
  output logic [pio_host_pkg::base_w-1:0]   jmp_pin1,
  input  logic [pio_isa_pkg::pc_w-1:0]      pc0,
  input  logic [pio_isa_pkg::pc_w-1:0]      pc1,
  output logic [15:0]                       instr0,
  output logic [15:0]                       instr1,
  output logic [1:0]                        tx_push,
  output logic [31:0]                       tx_data,
  output logic [1:0]                        rx_pull,
  input  logic [31:0]                       rx_dout0,
  input  logic [31:0]                       rx_dout1,
  input  logic [1:0]                        rx_empty,
  input  logic [1:0]                        tx_full
);

  typedef enum logic [1:0] {idle, act, hold} state_e;

  state_e                      state;
  pio_host_pkg::host_action_e  cmd;
  logic                        can_do;
  logic                        fire;
  logic [15:0]                 imem [pio_isa_pkg::imem_depth];
  logic [pio_isa_pkg::pc_w-1:0]     pstart    [pio_isa_pkg::num_machines];
  logic [pio_isa_pkg::pc_w-1:0]     pend      [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  out_base  [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::count_w-1:0] out_count [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  set_base  [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::count_w-1:0] set_count [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  in_base   [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  jmp_pin   [pio_isa_pkg::num_machines];

  assign cmd = pio_host_pkg::host_action_e'(action);

  // FIFO back-pressure holds the command in act
  always_comb begin
    case (cmd)
      pio_host_pkg::act_write_tx: can_do = !tx_full[mindex];
      pio_host_pkg::act_read_rx:  can_do = !rx_empty[mindex];
      default:                    can_do = 1'b1;
    endcase
  end

  assign fire    = (state == act) && can_do;
  assign tx_push = {2{fire && cmd == pio_host_pkg::act_write_tx}} & {mindex, !mindex};
  assign rx_pull = {2{fire && cmd == pio_host_pkg::act_read_rx}} & {mindex, !mindex};
  assign tx_data = din;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      ack   <= 1'b0;
      en    <= 2'b00;
      for (int i = 0; i < pio_isa_pkg::num_machines; i++) begin
        pstart[i]    <= '0;
        pend[i]      <= '0;
        out_base[i]  <= '0;
        out_count[i] <= '0;
        set_base[i]  <= '0;
        set_count[i] <= '0;
        in_base[i]   <= '0;
        jmp_pin[i]   <= '0;
      end
    end else begin
      case (state)
        idle: if (req) state <= act;
        act: begin
          if (can_do) begin
            ack   <= 1'b1;
            state <= hold;
            case (cmd)
              pio_host_pkg::act_set_wrap: begin
                pstart[mindex] <= din[pio_isa_pkg::pc_w-1:0];
                pend[mindex]   <= index;
              end
              pio_host_pkg::act_set_pins: begin
                set_count[mindex] <= din[pio_host_pkg::set_count_lsb +: pio_host_pkg::count_w];
                set_base[mindex]  <= din[pio_host_pkg::set_base_lsb +: pio_host_pkg::base_w];
                out_count[mindex] <= din[pio_host_pkg::out_count_lsb +: pio_host_pkg::count_w];
                out_base[mindex]  <= din[pio_host_pkg::out_base_lsb +: pio_host_pkg::base_w];
                in_base[mindex]   <= din[pio_host_pkg::in_base_lsb +: pio_host_pkg::base_w];
              end
              pio_host_pkg::act_enable:      en <= din[1:0];
              pio_host_pkg::act_set_jmp_pin: jmp_pin[mindex] <= din[pio_host_pkg::base_w-1:0];
              default: ;  // FIFO and memory actions handled elsewhere
            endcase
          end
        end
        hold: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire && cmd == pio_host_pkg::act_load_instr) imem[index] <= din[15:0];
    if (fire && cmd == pio_host_pkg::act_read_rx) dout <= mindex ? rx_dout1 : rx_dout0;
  end

  assign instr0     = imem[pc0];
  assign instr1     = imem[pc1];
  assign pstart0    = pstart[0];
  assign pend0      = pend[0];
  assign out_base0  = out_base[0];
  assign out_count0 = out_count[0];
  assign set_base0  = set_base[0];
  assign set_count0 = set_count[0];
  assign in_base0   = in_base[0];
  assign jmp_pin0   = jmp_pin[0];
  assign pstart1    = pstart[1];
  assign pend1      = pend[1];
  assign out_base1  = out_base[1];
  assign out_count1 = out_count[1];
  assign set_base1  = set_base[1];
  assign set_count1 = set_count[1];
  assign in_base1   = in_base[1];
  assign jmp_pin1   = jmp_pin[1];

  a_ack_after_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
    else $error("ack raised without a pending req");

endmodule

//--- logic/pio_isa_pkg.sv
package pio_isa_pkg;

  localparam int num_machines = 2;
  localparam int imem_depth   = 32;
  localparam int pc_w         = $clog2(imem_depth);
  localparam int fifo_depth   = 4;

  // Instruction field positions
  localparam int op_msb      = 15;
  localparam int op_lsb      = 13;
  localparam int operand_msb = 4;   // Jump target, SET data, bit count or pin index
  localparam int operand_lsb = 0;
  localparam int cond_msb    = 6;   // JMP condition or SET destination
  localparam int cond_lsb    = 5;
  localparam int wait_pol    = 7;

  typedef enum logic [2:0] {
    op_jmp  = 3'd0,
    op_wait = 3'd1,
    op_in   = 3'd2,
    op_out  = 3'd3,
    op_push = 3'd4,
    op_pull = 3'd5,
    op_set  = 3'd6
  } opcode_e;

  typedef enum logic [1:0] {
    jmp_always    = 2'd0,
    x_nonzero_dec = 2'd1,
    pin_high      = 2'd2
  } jmp_cond_e;

  typedef enum logic [1:0] {
    pins    = 2'd0,
    pindirs = 2'd1,
    x       = 2'd2
  } set_dest_e;

endpackage

//--- logic/pio_machine.sv
`timescale 1ns/1ns

module pio_machine (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              en,
  input  logic [15:0]                       instr,
  output logic [pio_isa_pkg::pc_w-1:0]      pc,
  input  logic [pio_isa_pkg::pc_w-1:0]      pstart,
  input  logic [pio_isa_pkg::pc_w-1:0]      pend,
  input  logic [pio_host_pkg::base_w-1:0]   out_base,
  input  logic [pio_host_pkg::count_w-1:0]  out_count,
  input  logic [pio_host_pkg::base_w-1:0]   set_base,
  input  logic [pio_host_pkg::count_w-1:0]  set_count,
  input  logic [pio_host_pkg::base_w-1:0]   in_base,
  input  logic [pio_host_pkg::base_w-1:0]   jmp_pin,
  input  logic [31:0]                       gpio_in,
  output logic [31:0]                       pin_values,
  output logic [31:0]                       pin_mask,
  output logic [31:0]                       dir_values,
  output logic [31:0]                       dir_mask,
  input  logic [31:0]                       tx_data,
  input  logic                              tx_empty,
  output logic                              tx_pull,
  output logic [31:0]                       rx_data,
  input  logic                              rx_full,
  output logic                              rx_push
);

  pio_isa_pkg::opcode_e   op;
  pio_isa_pkg::jmp_cond_e cond;
  pio_isa_pkg::set_dest_e dest;
  logic [4:0]  operand;
  logic        polarity;
  logic [31:0] isr;
  logic [31:0] osr;
  logic [31:0] x;
  logic        stall;
  logic        jmp_taken;
  logic [3:0]  out_win;
  logic [3:0]  set_win;
  logic [3:0]  out_n;
  logic [31:0] out_field;
  logic [31:0] set_field;
  logic [31:0] in_bits;

  assign op       = pio_isa_pkg::opcode_e'(instr[pio_isa_pkg::op_msb:pio_isa_pkg::op_lsb]);
  assign cond     = pio_isa_pkg::jmp_cond_e'(instr[pio_isa_pkg::cond_msb:pio_isa_pkg::cond_lsb]);
  assign dest     = pio_isa_pkg::set_dest_e'(instr[pio_isa_pkg::cond_msb:pio_isa_pkg::cond_lsb]);
  assign operand  = instr[pio_isa_pkg::operand_msb:pio_isa_pkg::operand_lsb];
  assign polarity = instr[pio_isa_pkg::wait_pol];

  // A zero count selects a full window of 8 pins
  assign out_win   = (out_count == '0) ? 4'd8 : {1'b0, out_count};
  assign set_win   = (set_count == '0) ? 4'd8 : {1'b0, set_count};
  assign out_n     = (operand > out_win) ? out_win : operand[3:0];
  assign out_field = (32'h1 << out_n) - 32'h1;
  assign set_field = (32'h1 << set_win) - 32'h1;
  assign in_bits   = (gpio_in >> in_base) & ((32'h1 << operand) - 32'h1);
  assign rx_data   = isr;

  always_comb begin
    stall      = 1'b0;
    jmp_taken  = 1'b0;
    tx_pull    = 1'b0;
    rx_push    = 1'b0;
    pin_values = '0;
    pin_mask   = '0;
    dir_values = '0;
    dir_mask   = '0;
    if (en) begin
      case (op)
        pio_isa_pkg::op_jmp: begin
          case (cond)
            pio_isa_pkg::jmp_always:    jmp_taken = 1'b1;
            pio_isa_pkg::x_nonzero_dec: jmp_taken = (x != '0);
            pio_isa_pkg::pin_high:      jmp_taken = gpio_in[jmp_pin];
            default:                    jmp_taken = 1'b0;
          endcase
        end
        pio_isa_pkg::op_wait: stall = (gpio_in[operand] != polarity);
        pio_isa_pkg::op_out: begin
          pin_values = (osr & out_field) << out_base;
          pin_mask   = out_field << out_base;
        end
        pio_isa_pkg::op_push: begin
          stall   = rx_full;
          rx_push = !rx_full;
        end
        pio_isa_pkg::op_pull: begin
          stall   = tx_empty;
          tx_pull = !tx_empty;
        end
        pio_isa_pkg::op_set: begin
          case (dest)
            pio_isa_pkg::pins: begin
              pin_values = ({27'b0, operand} & set_field) << set_base;
              pin_mask   = set_field << set_base;
            end
            pio_isa_pkg::pindirs: begin
              dir_values = ({27'b0, operand} & set_field) << set_base;
              dir_mask   = set_field << set_base;
            end
            default: ;  // x is written in the register block
          endcase
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc  <= '0;
      isr <= '0;
      osr <= '0;
      x   <= '0;
    end else if (!en) begin
      pc  <= pstart;
      isr <= '0;
      osr <= '0;
      x   <= '0;
    end else begin
      case (op)
        pio_isa_pkg::op_jmp: begin
          if (cond == pio_isa_pkg::x_nonzero_dec && jmp_taken) x <= x - 1'b1;
        end
        pio_isa_pkg::op_in:   isr <= (isr << operand) | in_bits;  // Enters from the right
        pio_isa_pkg::op_out:  osr <= osr >> operand;
        pio_isa_pkg::op_push: if (rx_push) isr <= '0;
        pio_isa_pkg::op_pull: if (tx_pull) osr <= tx_data;
        pio_isa_pkg::op_set:  if (dest == pio_isa_pkg::x) x <= {27'b0, operand};
        default: ;
      endcase
      if (jmp_taken) begin
        pc <= operand;
      end else if (!stall) begin
        pc <= (pc == pend) ? pstart : pc + 1'b1;  // Wrap at program end
      end
    end
  end

  a_shift_count: assert property (@(posedge clk) disable iff (reset)
    (en && (op == pio_isa_pkg::op_in || op == pio_isa_pkg::op_out))
      |-> (operand >= 5'd1 && operand <= 5'd8))
    else $error("IN or OUT bit count outside 1 to 8");

endmodule

//--- logic/pio_pin_merge.sv
`timescale 1ns/1ns

module pio_pin_merge (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pin_values0,
  input  logic [31:0] pin_mask0,
  input  logic [31:0] dir_values0,
  input  logic [31:0] dir_mask0,
  input  logic [31:0] pin_values1,
  input  logic [31:0] pin_mask1,
  input  logic [31:0] dir_values1,
  input  logic [31:0] dir_mask1,
  output logic [31:0] gpio_out,
  output logic [31:0] gpio_dir
);

  logic [31:0] out_next;
  logic [31:0] dir_next;

  // Machine 1 applied last so it wins on shared pins
  always_comb begin
    out_next = (gpio_out & ~pin_mask0) | (pin_values0 & pin_mask0);
    out_next = (out_next & ~pin_mask1) | (pin_values1 & pin_mask1);
    dir_next = (gpio_dir & ~dir_mask0) | (dir_values0 & dir_mask0);
    dir_next = (dir_next & ~dir_mask1) | (dir_values1 & dir_mask1);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out <= '0;
      gpio_dir <= '0;
    end else begin
      gpio_out <= out_next;
      gpio_dir <= dir_next;
    end
  end

endmodule

//--- logic/pio_top.sv
`timescale 1ns/1ns

module pio_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        req,
  output logic        ack,
  input  logic [3:0]  action,
  input  logic        mindex,
  input  logic [4:0]  index,
  input  logic [31:0] din,
  output logic [31:0] dout,
  input  logic [31:0] gpio_in,
  output logic [31:0] gpio_out,
  output logic [31:0] gpio_dir
);

  logic [1:0]                       en;
  logic [pio_isa_pkg::pc_w-1:0]     pstart     [pio_isa_pkg::num_machines];
  logic [pio_isa_pkg::pc_w-1:0]     pend       [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  out_base   [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::count_w-1:0] out_count  [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  set_base   [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::count_w-1:0] set_count  [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  in_base    [pio_isa_pkg::num_machines];
  logic [pio_host_pkg::base_w-1:0]  jmp_pin    [pio_isa_pkg::num_machines];
  logic [pio_isa_pkg::pc_w-1:0]     pc         [pio_isa_pkg::num_machines];
  logic [15:0]                      instr      [pio_isa_pkg::num_machines];
  logic [31:0]                      pin_values [pio_isa_pkg::num_machines];
  logic [31:0]                      pin_mask   [pio_isa_pkg::num_machines];
  logic [31:0]                      dir_values [pio_isa_pkg::num_machines];
  logic [31:0]                      dir_mask   [pio_isa_pkg::num_machines];
  logic [31:0]                      tx_dout    [pio_isa_pkg::num_machines];
  logic [31:0]                      rx_data    [pio_isa_pkg::num_machines];
  logic [31:0]                      rx_dout    [pio_isa_pkg::num_machines];
  logic [31:0]                      tx_data;
  logic [1:0]                       tx_push;
  logic [1:0]                       tx_pull;
  logic [1:0]                       tx_empty;
  logic [1:0]                       tx_full;
  logic [1:0]                       rx_push;
  logic [1:0]                       rx_pull;
  logic [1:0]                       rx_empty;
  logic [1:0]                       rx_full;

  pio_host_port u_host (
    .clk(clk),
    .reset(reset),
    .req(req),
    .ack(ack),
    .action(action),
    .mindex(mindex),
    .index(index),
    .din(din),
    .dout(dout),
    .en(en),
    .pstart0(pstart[0]),
    .pend0(pend[0]),
    .out_base0(out_base[0]),
    .out_count0(out_count[0]),
    .set_base0(set_base[0]),
    .set_count0(set_count[0]),
    .in_base0(in_base[0]),
    .jmp_pin0(jmp_pin[0]),
    .pstart1(pstart[1]),
    .pend1(pend[1]),
    .out_base1(out_base[1]),
    .out_count1(out_count[1]),
    .set_base1(set_base[1]),
    .set_count1(set_count[1]),
    .in_base1(in_base[1]),
    .jmp_pin1(jmp_pin[1]),
    .pc0(pc[0]),
    .pc1(pc[1]),
    .instr0(instr[0]),
    .instr1(instr[1]),
    .tx_push(tx_push),
    .tx_data(tx_data),
    .rx_pull(rx_pull),
    .rx_dout0(rx_dout[0]),
    .rx_dout1(rx_dout[1]),
    .rx_empty(rx_empty),
    .tx_full(tx_full)
  );

  for (genvar m = 0; m < pio_isa_pkg::num_machines; m++) begin : g_sm
    pio_machine u_machine (
      .clk(clk),
      .reset(reset),
      .en(en[m]),
      .instr(instr[m]),
      .pc(pc[m]),
      .pstart(pstart[m]),
      .pend(pend[m]),
      .out_base(out_base[m]),
      .out_count(out_count[m]),
      .set_base(set_base[m]),
      .set_count(set_count[m]),
      .in_base(in_base[m]),
      .jmp_pin(jmp_pin[m]),
      .gpio_in(gpio_in),
      .pin_values(pin_values[m]),
      .pin_mask(pin_mask[m]),
      .dir_values(dir_values[m]),
      .dir_mask(dir_mask[m]),
      .tx_data(tx_dout[m]),
      .tx_empty(tx_empty[m]),
      .tx_pull(tx_pull[m]),
      .rx_data(rx_data[m]),
      .rx_full(rx_full[m]),
      .rx_push(rx_push[m])
    );

    pio_fifo u_tx_fifo (  // Host to machine
      .clk(clk),
      .reset(reset),
      .push(tx_push[m]),
      .pull(tx_pull[m]),
      .din(tx_data),
      .dout(tx_dout[m]),
      .empty(tx_empty[m]),
      .full(tx_full[m])
    );

    pio_fifo u_rx_fifo (  // Machine to host
      .clk(clk),
      .reset(reset),
      .push(rx_push[m]),
      .pull(rx_pull[m]),
      .din(rx_data[m]),
      .dout(rx_dout[m]),
      .empty(rx_empty[m]),
      .full(rx_full[m])
    );
  end

  pio_pin_merge u_merge (
    .clk(clk),
    .reset(reset),
    .pin_values0(pin_values[0]),
    .pin_mask0(pin_mask[0]),
    .dir_values0(dir_values[0]),
    .dir_mask0(dir_mask[0]),
    .pin_values1(pin_values[1]),
    .pin_mask1(pin_mask[1]),
    .dir_values1(dir_values[1]),
    .dir_mask1(dir_mask[1]),
    .gpio_out(gpio_out),
    .gpio_dir(gpio_dir)
  );

endmodule

//--- src.f
logic/pio_isa_pkg.sv
logic/pio_host_pkg.sv
logic/pio_fifo.sv
logic/pio_machine.sv
logic/pio_pin_merge.sv
logic/pio_host_port.sv
logic/pio_top.sv
test/pio_clock_gen.sv
test/pio_tb.sv

//--- test/pio_clock_gen.sv
`timescale 1ns/1ns

module pio_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period  = 50;  // 100 ns clock
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- test/pio_tb.sv
`timescale 1ns/1ns

module pio_tb;

  localparam int test_cycles    = 600;  // Rough sum of all test lengths
  localparam int timeout_cycles = 5 * test_cycles;
  localparam int stall_cycles   = 20;   // Cycles a blocked command is watched

  logic        clk;
  logic        reset;
  logic        req;
  logic        ack;
  logic [3:0]  action;
  logic        mindex;
  logic [4:0]  index;
  logic [31:0] din;
  logic [31:0] dout;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_dir;
  logic        pin31;
  integer      seed;
  int          cycle_count = 0;
  logic        check_dout;
  logic [31:0] exp_dout;
  logic        check_gpio;
  logic [31:0] gpio_mask;
  logic [31:0] exp_out;
  logic [31:0] exp_dir;
  logic        expect_no_ack;
  logic [31:0] word;
  logic [3:0]  set_data;
  logic [3:0]  other_data;

  pio_clock_gen u_clock (
    .clk(clk),
    .reset(reset)
  );

  pio_top uut (
    .clk(clk),
    .reset(reset),
    .req(req),
    .ack(ack),
    .action(action),
    .mindex(mindex),
    .index(index),
    .din(din),
    .dout(dout),
    .gpio_in(gpio_in),
    .gpio_out(gpio_out),
    .gpio_dir(gpio_dir)
  );

  // Low byte loops back, pin 31 comes from the testbench
  assign gpio_in = {pin31, 23'b0, gpio_out[7:0]};

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  a_ack_rise: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
    else report_failure("ack rose while req was low");
  a_ack_fall: assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req))
    else report_failure("ack fell while req was still high");
  a_no_ack: assert property (@(posedge clk) disable iff (reset) expect_no_ack |-> !ack)
    else report_failure("ack given to a command that the FIFO state should block");
  a_dout: assert property (@(posedge clk) disable iff (reset)
    (check_dout && ack) |-> dout == exp_dout)
    else report_failure($sformatf("MISMATCH dout expected %h actual %h",
      $sampled(exp_dout), $sampled(dout)));
  a_gpio_out: assert property (@(posedge clk) disable iff (reset)
    check_gpio |-> (gpio_out & gpio_mask) == exp_out)
    else report_failure($sformatf("MISMATCH gpio_out expected %h actual %h",
      $sampled(exp_out), $sampled(gpio_out) & $sampled(gpio_mask)));
  a_gpio_dir: assert property (@(posedge clk) disable iff (reset)
    check_gpio |-> (gpio_dir & gpio_mask) == exp_dir)
    else report_failure($sformatf("MISMATCH gpio_dir expected %h actual %h",
      $sampled(exp_dir), $sampled(gpio_dir) & $sampled(gpio_mask)));

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin : watchdog
    wait (cycle_count >= timeout_cycles);
    report_failure($sformatf("Timeout, run not finished after %0d cycles", cycle_count));
  end

  function automatic logic [15:0] build_instr(input pio_isa_pkg::opcode_e op,
                                              input logic [1:0] sel, input logic pol,
                                              input logic [4:0] operand);
    logic [15:0] instr;
    instr = '0;
    instr[pio_isa_pkg::op_msb:pio_isa_pkg::op_lsb] = op;
    instr[pio_isa_pkg::cond_msb:pio_isa_pkg::cond_lsb] = sel;  // Condition or destination
    instr[pio_isa_pkg::wait_pol] = pol;
    instr[pio_isa_pkg::operand_msb:pio_isa_pkg::operand_lsb] = operand;
    return instr;
  endfunction

  task automatic start_command(input pio_host_pkg::host_action_e act_code, input logic m,
                               input logic [4:0] idx, input logic [31:0] data);
    @(negedge clk);
    action = act_code;
    mindex = m;
    index  = idx;
    din    = data;
    req    = 1'b1;
  endtask

  task automatic wait_for_ack();
    do @(negedge clk); while (!ack);
  endtask

  task automatic release_command();
    req = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic send_command(input pio_host_pkg::host_action_e act_code, input logic m,
                              input logic [4:0] idx, input logic [31:0] data);
    start_command(act_code, m, idx, data);
    wait_for_ack();
    release_command();
  endtask

  task automatic load_instr(input logic [4:0] idx, input logic [15:0] instr);
    send_command(pio_host_pkg::act_load_instr, 1'b0, idx, {16'b0, instr});
  endtask

  task automatic set_wrap(input logic m, input logic [4:0] start, input logic [4:0] stop);
    send_command(pio_host_pkg::act_set_wrap, m, stop, {27'b0, start});
  endtask

  task automatic configure_pins(input logic m, input logic [4:0] sbase, input logic [2:0] scount,
                                input logic [4:0] obase, input logic [2:0] ocount,
                                input logic [4:0] ibase);
    logic [31:0] cfg;
    cfg = '0;
    cfg[pio_host_pkg::set_count_lsb +: pio_host_pkg::count_w] = scount;
    cfg[pio_host_pkg::set_base_lsb +: pio_host_pkg::base_w]   = sbase;
    cfg[pio_host_pkg::out_count_lsb +: pio_host_pkg::count_w] = ocount;
    cfg[pio_host_pkg::out_base_lsb +: pio_host_pkg::base_w]   = obase;
    cfg[pio_host_pkg::in_base_lsb +: pio_host_pkg::base_w]    = ibase;
    send_command(pio_host_pkg::act_set_pins, m, 5'd0, cfg);
  endtask

  task automatic enable_machines(input logic [1:0] mask);
    send_command(pio_host_pkg::act_enable, 1'b0, 5'd0, {30'b0, mask});
  endtask

  task automatic read_and_check(input logic m, input logic [31:0] expected);
    exp_dout   = expected;
    check_dout = 1'b1;
    send_command(pio_host_pkg::act_read_rx, m, 5'd0, 32'h0);
    check_dout = 1'b0;
  endtask

  // Watches a blocked command for a while, ack must stay low
  task automatic watch_stall();
    expect_no_ack = 1'b1;
    repeat (stall_cycles) @(negedge clk);
    expect_no_ack = 1'b0;
  endtask

  task automatic enable_and_check(input logic [1:0] mask, input logic [31:0] window,
                                  input logic [31:0] out_val, input logic [31:0] dir_val);
    start_command(pio_host_pkg::act_enable, 1'b0, 5'd0, {30'b0, mask});
    wait_for_ack();
    release_command();  // One cycle after the ack
    @(negedge clk);     // Two cycles after, pins must be written
    gpio_mask  = window;
    exp_out    = out_val;
    exp_dir    = dir_val;
    check_gpio = 1'b1;
    repeat (3) @(negedge clk);
    check_gpio = 1'b0;
  endtask

  initial begin
    req           = 1'b0;
    action        = '0;
    mindex        = 1'b0;
    index         = '0;
    din           = '0;
    pin31         = 1'b0;
    check_dout    = 1'b0;
    exp_dout      = '0;
    check_gpio    = 1'b0;
    gpio_mask     = '0;
    exp_out       = '0;
    exp_dir       = '0;
    expect_no_ack = 1'b0;
    seed          = 32'h115d294d;
    wait (!reset);
    @(negedge clk);

    // Loopback through machine 0, count 0 is a full 8-pin window
    load_instr(5'd0, build_instr(pio_isa_pkg::op_pull, 2'd0, 1'b0, 5'd0));
    load_instr(5'd1, build_instr(pio_isa_pkg::op_out, 2'd0, 1'b0, 5'd8));
    load_instr(5'd2, build_instr(pio_isa_pkg::op_in, 2'd0, 1'b0, 5'd8));
    load_instr(5'd3, build_instr(pio_isa_pkg::op_push, 2'd0, 1'b0, 5'd0));
    set_wrap(1'b0, 5'd0, 5'd3);
    configure_pins(1'b0, 5'd0, 3'd0, 5'd0, 3'd0, 5'd0);
    enable_machines(2'b01);
    word = $random(seed);
    send_command(pio_host_pkg::act_write_tx, 1'b0, 5'd0, word);
    read_and_check(1'b0, {24'b0, word[7:0]});

    // SET pindirs then SET pins on a 4-pin window at pin 8
    enable_machines(2'b00);
    set_data = $random(seed);
    if (set_data == 4'h0) set_data = 4'h9;
    load_instr(5'd4, build_instr(pio_isa_pkg::op_set, pio_isa_pkg::pindirs, 1'b0, 5'(set_data)));
    load_instr(5'd5, build_instr(pio_isa_pkg::op_set, pio_isa_pkg::pins, 1'b0, 5'(set_data)));
    load_instr(5'd6, build_instr(pio_isa_pkg::op_jmp, pio_isa_pkg::jmp_always, 1'b0, 5'd6));
    set_wrap(1'b0, 5'd4, 5'd6);
    configure_pins(1'b0, 5'd8, 3'd4, 5'd0, 3'd0, 5'd0);
    enable_and_check(2'b01, 32'h0000_0f00, {20'b0, set_data, 8'b0}, {20'b0, set_data, 8'b0});

    // Both machines SET the same window in the same cycle
    enable_machines(2'b00);
    set_data = $random(seed);
    if (set_data == 4'h0) set_data = 4'h6;
    other_data = ~set_data;
    load_instr(5'd8, build_instr(pio_isa_pkg::op_set, pio_isa_pkg::pins, 1'b0, 5'(other_data)));
    load_instr(5'd9, build_instr(pio_isa_pkg::op_jmp, pio_isa_pkg::jmp_always, 1'b0, 5'd9));
    load_instr(5'd10, build_instr(pio_isa_pkg::op_set, pio_isa_pkg::pins, 1'b0, 5'(set_data)));
    load_instr(5'd11, build_instr(pio_isa_pkg::op_jmp, pio_isa_pkg::jmp_always, 1'b0, 5'd11));
    set_wrap(1'b0, 5'd8, 5'd9);
    set_wrap(1'b1, 5'd10, 5'd11);
    configure_pins(1'b0, 5'd12, 3'd4, 5'd0, 3'd0, 5'd0);
    configure_pins(1'b1, 5'd12, 3'd4, 5'd0, 3'd0, 5'd0);
    enable_and_check(2'b11, 32'h0000_f000, {16'b0, set_data, 12'b0}, 32'h0);

    // Countdown of three pushes gated by pin 31, then parked on pin 31 low
    enable_machines(2'b00);
    load_instr(5'd12, build_instr(pio_isa_pkg::op_set, pio_isa_pkg::x, 1'b0, 5'd2));
    load_instr(5'd13, build_instr(pio_isa_pkg::op_wait, 2'd0, 1'b1, 5'd31));
    load_instr(5'd14, build_instr(pio_isa_pkg::op_push, 2'd0, 1'b0, 5'd0));
    load_instr(5'd15, build_instr(pio_isa_pkg::op_jmp, pio_isa_pkg::x_nonzero_dec, 1'b0, 5'd13));
    load_instr(5'd16, build_instr(pio_isa_pkg::op_wait, 2'd0, 1'b0, 5'd31));
    load_instr(5'd17, build_instr(pio_isa_pkg::op_push, 2'd0, 1'b0, 5'd0));
    set_wrap(1'b0, 5'd12, 5'd17);
    enable_machines(2'b01);
    exp_dout   = 32'h0;  // Nothing shifted in, so each word is zero
    check_dout = 1'b1;
    start_command(pio_host_pkg::act_read_rx, 1'b0, 5'd0, 32'h0);
    watch_stall();
    pin31 = 1'b1;
    wait_for_ack();
    release_command();
    send_command(pio_host_pkg::act_read_rx, 1'b0, 5'd0, 32'h0);
    send_command(pio_host_pkg::act_read_rx, 1'b0, 5'd0, 32'h0);
    start_command(pio_host_pkg::act_read_rx, 1'b0, 5'd0, 32'h0);
    watch_stall();    // No fourth word yet
    pin31 = 1'b0;     // Lets the trailing PUSH complete this read
    wait_for_ack();
    release_command();
    check_dout = 0;

    // Transmit back-pressure, machine 0 held at a WAIT before its PULL loop
    enable_machines(2'b00);
    load_instr(5'd18, build_instr(pio_isa_pkg::op_wait, 2'd0, 1'b1, 5'd31));
    load_instr(5'd19, build_instr(pio_isa_pkg::op_pull, 2'd0, 1'b0, 5'd0));
    load_instr(5'd20, build_instr(pio_isa_pkg::op_jmp, pio_isa_pkg::jmp_always, 1'b0, 5'd19));
    set_wrap(1'b0, 5'd18, 5'd20);
    enable_machines(2'b01);
    repeat (pio_isa_pkg::fifo_depth) begin
      word = $random(seed);
      send_command(pio_host_pkg::act_write_tx, 1'b0, 5'd0, word);
    end
    word = $random(seed);
    start_command(pio_host_pkg::act_write_tx, 1'b0, 5'd0, word);
    watch_stall();
    pin31 = 1'b1;  // PULL loop starts draining
    wait_for_ack();
    release_command();

    repeat (4) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
